// ==== src/probe_pkg.sv ====
`default_nettype none

package probe_pkg;

  // address split for a 64-set, 64-byte-line cache
  localparam int unsigned addr_w = 32;
  localparam int unsigned idx_lsb = 6;
  localparam int unsigned idx_msb = 11;
  localparam int unsigned tag_lsb = 12;
  localparam int unsigned idx_w = 6;
  localparam int unsigned tag_w = 20;
  localparam int unsigned n_ways = 8;
  localparam int unsigned source_w = 3;
  localparam int unsigned size_w = 4;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [idx_w-1:0] idx_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [n_ways-1:0] way_mask_t;
  typedef logic [source_w-1:0] source_t;
  typedef logic [size_w-1:0] size_t;

  // coherence state held per cache line
  typedef enum logic [1:0] {
    nothing = 2'd0,
    branch  = 2'd1,
    trunk   = 2'd2,
    dirty   = 2'd3
  } coh_e;

  // capability the probe asks the cache to drop to
  typedef enum logic [1:0] {
    to_t = 2'd0,
    to_b = 2'd1,
    to_n = 2'd2
  } probe_param_e;

  // shrink or report code carried back in the ack or writeback
  typedef enum logic [2:0] {
    t_to_b = 3'd0,
    t_to_n = 3'd1,
    b_to_n = 3'd2,
    t_to_t = 3'd3,
    b_to_b = 3'd4,
    n_to_n = 3'd5
  } report_e;

  // incoming probe
  typedef struct packed {
    probe_param_e param;
    size_t        size;
    source_t      source;
    addr_t        address;
  } probe_req_t;

  // probe acknowledgement
  typedef struct packed {
    report_e report;
    size_t   size;
    source_t source;
    addr_t   address;
  } probe_ack_t;

  typedef struct packed {
    idx_t idx;
    tag_t tag;
  } meta_read_t;

  typedef struct packed {
    way_mask_t way_en;
    idx_t      idx;
    tag_t      tag;
    coh_e      coh;
  } meta_write_t;

  typedef struct packed {
    source_t   source;
    idx_t      idx;
    tag_t      tag;
    report_e   report;
    way_mask_t way_en;
  } wb_req_t;

  // output of the probe-response table
  typedef struct packed {
    logic    is_dirty;
    report_e report;
    coh_e    new_coh;
  } coh_result_t;

endpackage

`default_nettype wire

// ==== src/probe_req_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_req_regs
  import probe_pkg::*;
(
  input  wire logic clock,
  input  wire logic reset,
  input  probe_req_t req_in,
  input  wire logic req_load,
  input  wire logic lookup_load,
  input  way_mask_t way_en_in,
  input  coh_e      block_state,
  output probe_req_t req,
  output way_mask_t way_en,
  output idx_t      idx,
  output tag_t      tag,
  output logic      hit,
  output coh_e      reply_coh
);

  // state of the line before the probe
  coh_e old_coh;

  // probe is captured once, on the accepting handshake
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      req <= '0;
    end else if (req_load) begin
      req <= req_in;
    end
  end

  // lookup result is taken in the check cycle of every attempt
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      way_en  <= '0;
      old_coh <= nothing;
    end else if (lookup_load) begin
      way_en  <= way_en_in;
      old_coh <= block_state;
    end
  end

  // set index and tag come straight from the held address
  assign idx = req.address[idx_msb:idx_lsb];
  assign tag = req.address[addr_w-1:tag_lsb];

  // any way matching means the line is present
  assign hit = |way_en;

  // a miss answers as if the line held nothing
  assign reply_coh = hit ? old_coh : nothing;

endmodule

`default_nettype wire

// ==== src/probe_coh_table.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_coh_table
  import probe_pkg::*;
(
  input  probe_param_e param,
  input  coh_e         coh,
  output coh_result_t  result
);

  always_comb begin
    // unused param value falls back to a clean t_to_b, nothing
    result.is_dirty = 1'b0;
    result.report   = t_to_b;
    result.new_coh  = nothing;
    case (param)
      // keep whatever permission the line has
      to_t: begin
        case (coh)
          nothing: begin result.report = n_to_n; result.new_coh = nothing; end
          branch:  begin result.report = b_to_b; result.new_coh = branch;  end
          trunk:   begin result.report = t_to_t; result.new_coh = trunk;   end
          dirty: begin
            result.is_dirty = 1'b1;
            result.report   = t_to_t;
            result.new_coh  = trunk;
          end
          default: result.report = n_to_n;
        endcase
      end
      // shrink to branch at most
      to_b: begin
        case (coh)
          nothing: begin result.report = n_to_n; result.new_coh = nothing; end
          branch:  begin result.report = b_to_b; result.new_coh = branch;  end
          trunk:   begin result.report = t_to_b; result.new_coh = branch;  end
          dirty: begin
            result.is_dirty = 1'b1;
            result.report   = t_to_b;
            result.new_coh  = branch;
          end
          default: result.report = n_to_n;
        endcase
      end
      // give the line up entirely
      to_n: begin
        case (coh)
          nothing: begin result.report = n_to_n; result.new_coh = nothing; end
          branch:  begin result.report = b_to_n; result.new_coh = nothing; end
          trunk:   begin result.report = t_to_n; result.new_coh = nothing; end
          dirty: begin
            result.is_dirty = 1'b1;
            result.report   = t_to_n;
          end
          default: result.report = n_to_n;
        endcase
      end
      default: result.is_dirty = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/probe_fsm.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_fsm
  import probe_pkg::*;
(
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic req_valid,
  input  wire logic meta_read_ready,
  input  wire logic mshr_rdy,
  input  wire logic wb_rdy,
  input  wire logic hit,
  input  wire logic is_dirty,
  input  wire logic wb_req_ready,
  input  wire logic lsu_release_ready,
  input  wire logic rep_ready,
  input  wire logic meta_write_ready,
  output logic      req_ready,
  output logic      meta_read_valid,
  output logic      wb_req_valid,
  output logic      lsu_release_valid,
  output logic      rep_valid,
  output logic      meta_write_valid,
  output logic      mshr_wb_rdy,
  output logic      req_load,
  output logic      lookup_load
);

  typedef enum logic [3:0] {
    s_idle,
    s_meta_read,
    s_meta_wait,
    s_check,
    s_decide,
    s_lsu_release,
    s_ack,
    s_wb_req,
    s_wb_done,
    s_meta_write,
    s_meta_done
  } state_e;

  state_e state;

  // each valid is a plain decode of the current state
  always_comb begin
    req_ready         = (state == s_idle);
    meta_read_valid   = (state == s_meta_read);
    lsu_release_valid = (state == s_lsu_release);
    rep_valid         = (state == s_ack);
    wb_req_valid      = (state == s_wb_req);
    meta_write_valid  = (state == s_meta_write);
    // miss handler must not push lines to writeback while the probe owns the line
    mshr_wb_rdy = !(state inside {s_ack, s_wb_req, s_wb_done, s_meta_write, s_meta_done});
    req_load    = req_valid && (state == s_idle);
    lookup_load = (state == s_check);
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (req_valid) state <= s_meta_read;
        end
        s_meta_read: begin
          if (meta_read_ready) state <= s_meta_wait;
        end
        // metadata array answers one cycle later
        s_meta_wait: state <= s_check;
        // retry the read while either unit is busy with this set
        s_check: begin
          state <= (mshr_rdy && wb_rdy) ? s_decide : s_meta_read;
        end
        s_decide: begin
          state <= (hit && is_dirty) ? s_wb_req : s_lsu_release;
        end
        s_lsu_release: begin
          if (lsu_release_ready) state <= s_ack;
        end
        // only a hit has state to update after the ack
        s_ack: begin
          if (rep_ready) state <= hit ? s_meta_write : s_idle;
        end
        s_wb_req: begin
          if (wb_req_ready) state <= s_wb_done;
        end
        // ready going high again means the writeback unit finished the line
        s_wb_done: begin
          if (wb_req_ready) state <= s_meta_write;
        end
        s_meta_write: begin
          if (meta_write_ready) state <= s_meta_done;
        end
        s_meta_done: state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/probe_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_unit
  import probe_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  reset,
  // probe request in
  input  wire logic  req_valid,
  output logic       req_ready,
  input  probe_req_t req,
  // metadata array
  output logic        meta_read_valid,
  input  wire logic   meta_read_ready,
  output meta_read_t  meta_read,
  output logic        meta_write_valid,
  input  wire logic   meta_write_ready,
  output meta_write_t meta_write,
  // writeback unit
  output logic       wb_req_valid,
  input  wire logic  wb_req_ready,
  output wb_req_t    wb_req,
  // load/store unit release notice
  output logic       lsu_release_valid,
  input  wire logic  lsu_release_ready,
  output addr_t      lsu_release_addr,
  // acknowledgement out
  output logic       rep_valid,
  input  wire logic  rep_ready,
  output probe_ack_t rep,
  // lookup result and busy levels
  input  way_mask_t  way_en,
  input  coh_e       block_state,
  input  wire logic  mshr_rdy,
  input  wire logic  wb_rdy,
  output logic       mshr_wb_rdy
);

  probe_req_t  held_req;
  way_mask_t   held_way_en;
  idx_t        idx;
  tag_t        tag;
  logic        hit;
  coh_e        reply_coh;
  coh_result_t coh_res;
  logic        req_load;
  logic        lookup_load;

  probe_req_regs u_regs (
    .clock       (clock),
    .reset       (reset),
    .req_in      (req),
    .req_load    (req_load),
    .lookup_load (lookup_load),
    .way_en_in   (way_en),
    .block_state (block_state),
    .req         (held_req),
    .way_en      (held_way_en),
    .idx         (idx),
    .tag         (tag),
    .hit         (hit),
    .reply_coh   (reply_coh)
  );

  probe_coh_table u_table (
    .param  (held_req.param),
    .coh    (reply_coh),
    .result (coh_res)
  );

  probe_fsm u_fsm (
    .clock             (clock),
    .reset             (reset),
    .req_valid         (req_valid),
    .meta_read_ready   (meta_read_ready),
    .mshr_rdy          (mshr_rdy),
    .wb_rdy            (wb_rdy),
    .hit               (hit),
    .is_dirty          (coh_res.is_dirty),
    .wb_req_ready      (wb_req_ready),
    .lsu_release_ready (lsu_release_ready),
    .rep_ready         (rep_ready),
    .meta_write_ready  (meta_write_ready),
    .req_ready         (req_ready),
    .meta_read_valid   (meta_read_valid),
    .wb_req_valid      (wb_req_valid),
    .lsu_release_valid (lsu_release_valid),
    .rep_valid         (rep_valid),
    .meta_write_valid  (meta_write_valid),
    .mshr_wb_rdy       (mshr_wb_rdy),
    .req_load          (req_load),
    .lookup_load       (lookup_load)
  );

  // payloads are built only from held fields so they stay put under back-pressure
  always_comb begin
    meta_read.idx = idx;
    meta_read.tag = tag;

    meta_write.way_en = held_way_en;
    meta_write.idx    = idx;
    meta_write.tag    = tag;
    meta_write.coh    = coh_res.new_coh;

    wb_req.source = held_req.source;
    wb_req.idx    = idx;
    wb_req.tag    = tag;
    wb_req.report = coh_res.report;
    wb_req.way_en = held_way_en;

    // lsu only needs the line address to drop reservations
    lsu_release_addr = held_req.address;

    rep.report  = coh_res.report;
    rep.size    = held_req.size;
    rep.source  = held_req.source;
    rep.address = held_req.address;
  end

endmodule

`default_nettype wire

// ==== test/probe_unit_assertions.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_unit_assertions
  import probe_pkg::*;
(
  input wire logic   clock,
  input wire logic   reset,
  input wire logic   req_ready,
  input wire logic   mshr_wb_rdy,
  input wire logic   meta_read_valid,
  input wire logic   meta_read_ready,
  input meta_read_t  meta_read,
  input wire logic   meta_write_valid,
  input wire logic   meta_write_ready,
  input meta_write_t meta_write,
  input wire logic   wb_req_valid,
  input wire logic   wb_req_ready,
  input wb_req_t     wb_req,
  input wire logic   lsu_release_valid,
  input wire logic   lsu_release_ready,
  input addr_t       lsu_release_addr,
  input wire logic   rep_valid,
  input wire logic   rep_ready,
  input probe_ack_t  rep
);

  // idle unit requests nothing downstream
  assert property (@(posedge clock) disable iff (reset)
    req_ready |-> !(meta_read_valid || meta_write_valid || wb_req_valid
                    || lsu_release_valid || rep_valid))
    else $error("output valid high while idle");

  // each request holds with a constant payload until taken
  assert property (@(posedge clock) disable iff (reset)
    meta_read_valid && !meta_read_ready |=> meta_read_valid && $stable(meta_read))
    else $error("metadata read dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    meta_write_valid && !meta_write_ready |=> meta_write_valid && $stable(meta_write))
    else $error("metadata write dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    wb_req_valid && !wb_req_ready |=> wb_req_valid && $stable(wb_req))
    else $error("writeback request dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    lsu_release_valid && !lsu_release_ready |=> lsu_release_valid
                                                && $stable(lsu_release_addr))
    else $error("release notice dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    rep_valid && !rep_ready |=> rep_valid && $stable(rep))
    else $error("acknowledgement dropped or changed before transfer");

  // miss handler kept off writeback while the probe owns the line
  assert property (@(posedge clock) disable iff (reset)
    (rep_valid || meta_write_valid) |-> !mshr_wb_rdy)
    else $error("mshr_wb_rdy high during ack or metadata write");

endmodule

bind probe_unit probe_unit_assertions u_assertions (.*);

`default_nettype wire

// ==== test/probe_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module probe_unit_tb
  import probe_pkg::*;
();

  localparam int unsigned n_probes = 60;
  localparam int unsigned probe_timeout = 400;

  logic        clock;
  logic        reset;
  logic        req_valid, req_ready;
  probe_req_t  req;
  logic        meta_read_valid, meta_read_ready;
  meta_read_t  meta_read;
  logic        meta_write_valid, meta_write_ready;
  meta_write_t meta_write;
  logic        wb_req_valid, wb_req_ready;
  wb_req_t     wb_req;
  logic        lsu_release_valid, lsu_release_ready;
  addr_t       lsu_release_addr;
  logic        rep_valid, rep_ready;
  probe_ack_t  rep;
  way_mask_t   way_en;
  coh_e        block_state;
  logic        mshr_rdy, wb_rdy, mshr_wb_rdy;

  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned errors_before;
  logic        timed_out;

  probe_unit UUT (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  // back-pressure, each ready high about three cycles in four
  task automatic drive_readies();
    meta_read_ready   = ($urandom_range(3, 0) != 0);
    meta_write_ready  = ($urandom_range(3, 0) != 0);
    wb_req_ready      = ($urandom_range(3, 0) != 0);
    lsu_release_ready = ($urandom_range(3, 0) != 0);
    rep_ready         = ($urandom_range(3, 0) != 0);
  endtask

  // reference probe-response table
  function automatic void table_model(input probe_param_e param, input coh_e coh,
                                      output logic is_dirty, output report_e report,
                                      output coh_e new_coh);
    is_dirty = (coh == dirty);
    case (coh)
      nothing: begin
        report  = n_to_n;
        new_coh = nothing;
      end
      branch: begin
        report  = (param == to_n) ? b_to_n : b_to_b;
        new_coh = (param == to_n) ? nothing : branch;
      end
      // trunk and dirty answer alike, dirty just adds the writeback
      default: begin
        report  = (param == to_t) ? t_to_t : (param == to_b) ? t_to_b : t_to_n;
        new_coh = (param == to_t) ? trunk : (param == to_b) ? branch : nothing;
      end
    endcase
  endfunction

  task automatic run_probe(input int unsigned num);
    probe_req_t  pr;
    way_mask_t   ways;
    coh_e        state;
    logic        hit_exp;
    logic        dirty_exp;
    report_e     report_exp;
    coh_e        coh_exp;
    meta_read_t  read_exp;
    probe_ack_t  ack_exp;
    meta_write_t write_exp;
    wb_req_t     wb_exp;
    int unsigned seq;
    int unsigned seq_exp;
    int unsigned reads;
    int unsigned busy_count;
    int unsigned cycles;
    int unsigned errs_at_start;
    logic        accepted;
    logic        done;
    logic        busy;
    logic        read_seen;
    string       name;
    string       kind;
    name = $sformatf("probe_%0d", num);
    errs_at_start = errors;
    pr.param   = probe_param_e'(2'($urandom_range(2, 0)));
    pr.size    = size_t'($urandom);
    pr.source  = source_t'($urandom);
    pr.address = $urandom;
    // half the probes miss, the rest hit a single way
    ways  = ($urandom_range(1, 0) == 0) ? '0 : way_mask_t'(8'd1 << $urandom_range(7, 0));
    state = coh_e'(2'($urandom_range(3, 0)));

    // a miss answers as a line holding nothing
    hit_exp = (ways != '0);
    table_model(pr.param, hit_exp ? state : nothing, dirty_exp, report_exp, coh_exp);
    read_exp  = '{idx: pr.address[idx_msb:idx_lsb], tag: pr.address[addr_w-1:tag_lsb]};
    ack_exp   = '{report: report_exp, size: pr.size, source: pr.source, address: pr.address};
    write_exp = '{way_en: ways, idx: read_exp.idx, tag: read_exp.tag, coh: coh_exp};
    wb_exp    = '{source: pr.source, idx: read_exp.idx, tag: read_exp.tag,
                  report: report_exp, way_en: ways};
    // event codes in octal digits: 2 writeback, 3 release, 4 ack, 5 metadata write
    if (hit_exp && dirty_exp) begin
      seq_exp = 2 * 8 + 5;
      kind = "dirty hit";
    end else if (hit_exp) begin
      seq_exp = (3 * 8 + 4) * 8 + 5;
      kind = "clean hit";
    end else begin
      seq_exp = 3 * 8 + 4;
      kind = "miss";
    end

    req         = pr;
    req_valid   = 1'b1;
    way_en      = ways;
    block_state = state;
    seq        = 0;
    reads      = 0;
    busy_count = 0;
    cycles     = 0;
    accepted   = 1'b0;
    done       = 1'b0;
    busy       = 1'b0;
    while (!done && cycles < probe_timeout) begin
      // sample mid-cycle, transfers land on the next rising edge
      @(negedge clock);
      read_seen = 1'b0;
      if (accepted && req_ready) begin
        done = 1'b1;
      end else begin
        if (req_valid && req_ready) accepted = 1'b1;
        if (meta_read_valid && meta_read_ready) begin
          read_seen = 1'b1;
          reads++;
          check_value({name, " meta_read"}, 64'(read_exp), 64'(meta_read));
        end
        if (busy && (wb_req_valid || lsu_release_valid || rep_valid || meta_write_valid)) begin
          $display("%s: request went out while the miss handler or writeback was busy", name);
          errors++;
        end
        if (wb_req_valid && wb_req_ready) begin
          seq = seq * 8 + 2;
          check_value({name, " wb_req"}, 64'(wb_exp), 64'(wb_req));
        end
        if (lsu_release_valid && lsu_release_ready) begin
          seq = seq * 8 + 3;
          check_value({name, " release addr"}, 64'(pr.address), 64'(lsu_release_addr));
        end
        if (rep_valid && rep_ready) begin
          seq = seq * 8 + 4;
          check_value({name, " rep"}, 64'(ack_exp), 64'(rep));
        end
        if (meta_write_valid && meta_write_ready) begin
          seq = seq * 8 + 5;
          check_value({name, " meta_write"}, 64'(write_exp), 64'(meta_write));
        end
      end
      @(posedge clock);
      #1;
      drive_readies();
      if (accepted) req_valid = 1'b0;
      // busy levels hold for the whole attempt, forced free from the third try
      if (read_seen) begin
        mshr_rdy = (reads >= 3) || ($urandom_range(2, 0) != 0);
        wb_rdy   = (reads >= 3) || ($urandom_range(2, 0) != 0);
        busy     = !(mshr_rdy && wb_rdy);
        if (busy) busy_count++;
      end
      cycles++;
    end

    if (!done) begin
      $display("%s did not finish within %0d cycles", name, probe_timeout);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_value({name, " event order"}, 64'(seq_exp), 64'(seq));
      check_value({name, " read count"}, 64'(busy_count + 1), 64'(reads));
    end
    tests_run++;
    if (errors != errs_at_start) tests_failed++;
    $display("%s %s, %0d reads: %s", name, kind, reads,
             (errors == errs_at_start) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(32'h4cef0338));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    way_en       = '0;
    block_state  = nothing;
    mshr_rdy     = 1'b1;
    wb_rdy       = 1'b1;
    drive_readies();
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    // idle straight out of reset
    @(negedge clock);
    errors_before = errors;
    check_value("reset valids", 64'd0, 64'({meta_read_valid, meta_write_valid, wb_req_valid,
                                             lsu_release_valid, rep_valid}));
    check_value("reset req_ready", 64'd1, 64'(req_ready));
    check_value("reset mshr_wb_rdy", 64'd1, 64'(mshr_wb_rdy));
    tests_run++;
    if (errors != errors_before) tests_failed++;
    $display("reset: %s", (errors == errors_before) ? "ok" : "failed");
    @(posedge clock);
    #1;

    for (int unsigned i = 0; i < n_probes && !timed_out; i++) begin
      run_probe(i);
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== probe_unit.f ====
src/probe_pkg.sv
src/probe_req_regs.sv
src/probe_coh_table.sv
src/probe_fsm.sv
src/probe_unit.sv
test/probe_unit_assertions.sv
test/probe_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the probe unit testbench with Verilator, all output goes to sim.log
verilator --binary --timing --assert --top-module probe_unit_tb -f probe_unit.f \
  -o probe_unit_sim > sim.log 2>&1 &&
  ./obj_dir/probe_unit_sim >> sim.log 2>&1 ||
  echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
